// File: branch_vectors.txt
// Columns: pc ir raValue expectedNextPc expectedTaken (hex, one request per line)
// ir uses Ra = 1; condition field in bits 20:19, signed constant in bits 18:0
00000100 90800010 00000000 00000111 1
00000200 90800010 00000005 00000201 0
00000300 90800010 80000000 00000301 0
00000400 90880020 00000000 00000401 0
00000400 90880020 00000007 00000421 1
00001000 908FFFFC FFFFFFFF 00000FFD 1
00000500 90900008 00000000 00000509 1
00000600 90900008 7FFFFFFF 00000609 1
00000700 90900008 80000001 00000701 0
00000022 90980023 0000000F 00000023 0
00000800 90980023 00000000 00000801 0
00000800 90980023 FFFFFFF0 00000824 1
00002000 909FFFFC 80000000 00001FFD 1
FFFFFFF0 90800020 00000000 00000011 1
00000002 908FFFF8 00000001 FFFFFFFB 1
00100000 90940000 00000001 000C0001 1
00001000 9083FFFF 00000000 00041000 1
FFFFFFFF 90800010 00000001 00000000 0
00000900 28800000 00000000 00000901 0
00000A00 98800010 00000000 00000A01 0
00000B00 00000000 00000000 00000B01 0
00000C00 9087FFFC 00000003 00000C01 0
00000C00 9087FFFC 00000000 00000BFD 1
00000D00 9097FFFC FFFFFFFF 00000D01 0
00000E00 90980100 7FFFFFFF 00000E01 0
00000F00 90880000 00000001 00000F01 1

// File: build.f
brPkg.sv
creditQueue.sv
condEval.sv
targetAdder.sv
pcResolve.sv
branchUnit.sv
tb_branchUnit.sv

// File: tb_branchUnit.sv
module tb_branchUnit
    import brPkg::*;
;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int MAX_VEC     = 64;
    localparam int VEC_COLS    = 5;   // pc, ir, raValue, nextPc, taken
    localparam int HOLD_CYCLES = 60;  // Length of the withheld credit phase

    logic        clk;
    logic        rst;
    logic        reqValid;
    branchReq_t  reqData;
    logic        respCredit;
    logic        reqCredit;
    logic        respValid;
    branchResp_t respData;

    logic [31:0] vecMem [MAX_VEC*VEC_COLS];
    int          gapLen [MAX_VEC];
    int          creditDelay [MAX_VEC];
    int          numVec = 0;
    logic        loaded = 1'b0;
    logic        withhold = 1'b1;
    logic        creditOverrun = 1'b0;
    int          sentCount = 0;
    int          creditsReturned = 0;  // reqCredit pulses seen
    int          creditsGiven = 0;     // respCredit pulses seen
    int          creditsSent = 0;
    int          respCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    branchUnit dut0 (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .reqData    (reqData),
        .respCredit (respCredit),
        .reqCredit  (reqCredit),
        .respValid  (respValid),
        .respData   (respData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int countVectors();
        int n;
        n = 0;
        while (n < MAX_VEC && vecMem[n*VEC_COLS+4] <= 32'd1) begin  // Fill pattern stops it
            n++;
        end
        return n;
    endfunction

    function automatic branchReq_t makeRequest(input int idx);
        branchReq_t req;
        req.tag     = brTag_t'(idx);
        req.pc      = vecMem[idx*VEC_COLS];
        req.ir      = vecMem[idx*VEC_COLS+1];
        req.raValue = vecMem[idx*VEC_COLS+2];
        return req;
    endfunction

    task automatic reportTest(input string name, input logic ok);
        if (ok) begin
            passCount++;
            $display("%-24s pass", name);
        end else begin
            failCount++;
            $display("%-24s FAIL", name);
        end
    endtask

    task automatic checkResponse(input int idx);
        logic [31:0] expNext;
        logic        expTaken;
        logic        ok;
        ok = 1'b1;
        if (idx >= numVec) begin
            $display("Extra response with tag %0d at %0t, no request left", respData.tag, $time);
            failCount++;
        end else begin
            expNext  = vecMem[idx*VEC_COLS+3];
            expTaken = vecMem[idx*VEC_COLS+4][0];
            if (respData.tag !== brTag_t'(idx)) begin
                $display("Mismatch at %0t: response %0d has tag %0d", $time, idx, respData.tag);
                ok = 1'b0;
            end
            if (respData.nextPc !== expNext) begin
                $display("Mismatch at %0t: tag %0d nextPc %h, expected %h",
                         $time, idx, respData.nextPc, expNext);
                ok = 1'b0;
            end
            if (respData.taken !== expTaken) begin
                $display("Mismatch at %0t: tag %0d taken %b, expected %b",
                         $time, idx, respData.taken, expTaken);
                ok = 1'b0;
            end
            reportTest($sformatf("vector %0d", idx), ok);
        end
    endtask

    // Response and credit monitor on values from the cycle just ended
    always @(posedge clk) begin
        if (!rst) begin
            if (reqCredit) creditsReturned <= creditsReturned + 1;
            if (respCredit) creditsGiven <= creditsGiven + 1;
            if (respValid) begin
                if (respCount >= OUT_CREDITS + creditsGiven) begin
                    $display("Response sent at %0t without an output credit", $time);
                    creditOverrun = 1'b1;
                end
                checkResponse(respCount);
                respCount <= respCount + 1;
            end
        end
    end

    // Consumer hands back one credit per response
    initial begin
        respCredit = 1'b0;
        forever begin
            @(posedge clk);
            respCredit <= 1'b0;
            if (!withhold && creditsSent < respCount) begin
                repeat (creditDelay[creditsSent % MAX_VEC]) @(posedge clk);
                respCredit <= 1'b1;
                creditsSent++;
            end
        end
    end

    task automatic sendRequests();
        int i;
        for (i = 0; i < numVec; i++) begin
            repeat (gapLen[i]) begin
                @(posedge clk);
                reqValid <= 1'b0;
            end
            @(posedge clk);
            while (QUEUE_DEPTH + creditsReturned - sentCount <= 0) begin  // Out of credits
                reqValid <= 1'b0;
                @(posedge clk);
            end
            reqValid <= 1'b1;
            reqData  <= makeRequest(i);
            sentCount++;
        end
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic holdCredits();
        int  expSent;
        int  expResp;
        logic ok;
        expSent = (numVec < QUEUE_DEPTH + OUT_CREDITS) ? numVec : QUEUE_DEPTH + OUT_CREDITS;
        expResp = (numVec < OUT_CREDITS) ? numVec : OUT_CREDITS;
        repeat (HOLD_CYCLES) @(posedge clk);
        @(negedge clk);
        ok = 1'b1;
        if (respCount != expResp) begin
            $display("Mismatch at %0t: %0d responses while credits held, expected %0d",
                     $time, respCount, expResp);
            ok = 1'b0;
        end
        if (sentCount != expSent || creditsReturned != expResp) begin
            $display("Mismatch at %0t: sent %0d with %0d reqCredit pulses, expected %0d and %0d",
                     $time, sentCount, creditsReturned, expSent, expResp);
            ok = 1'b0;
        end
        reportTest("back-pressure", ok);
        @(posedge clk);
        withhold <= 1'b0;
    endtask

    task automatic runTests();
        logic ok;
        ok = 1'b1;
        repeat (15) begin
            @(negedge clk);
            if (respValid !== 1'b0 || reqCredit !== 1'b0) ok = 1'b0;
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (respValid !== 1'b0 || reqCredit !== 1'b0) ok = 1'b0;
        end
        if (!ok) $display("Mismatch at %0t: respValid or reqCredit high around reset", $time);
        reportTest("reset state", ok);

        fork
            sendRequests();
            holdCredits();
        join

        while (respCount < numVec) @(posedge clk);
        repeat (12) @(posedge clk);  // Room for a stray extra response
        @(negedge clk);
        ok = 1'b1;
        if (respCount != numVec) begin
            $display("Mismatch at %0t: %0d responses for %0d requests",
                     $time, respCount, numVec);
            ok = 1'b0;
        end
        reportTest("order and count", ok);
        reportTest("output credits", !creditOverrun);
        if (creditsReturned != sentCount) begin
            $display("Mismatch at %0t: %0d reqCredit pulses for %0d requests",
                     $time, creditsReturned, sentCount);
        end
        reportTest("input credits", creditsReturned == sentCount);
    endtask

    initial begin
        int a;
        rst      = 1'b1;
        reqValid = 1'b0;
        reqData  = '0;
        void'($urandom(66803));
        for (a = 0; a < MAX_VEC*VEC_COLS; a++) begin
            vecMem[a] = 32'hFFFF_0000 | 32'(a);
        end
        $readmemh("branch_vectors.txt", vecMem);
        numVec = countVectors();
        for (a = 0; a < MAX_VEC; a++) begin
            gapLen[a]      = $urandom_range(3);
            creditDelay[a] = $urandom_range(4);
        end
        loaded = 1'b1;
        if (numVec == 0) begin
            $display("No vectors could be read from branch_vectors.txt");
            failCount++;
        end else begin
            runTests();
        end
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog allowing 40 cycles per vector
    initial begin
        wait (loaded);
        repeat (((numVec > 0) ? numVec : 1) * 40) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", numVec * 40);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: branchUnit.sv
module branchUnit
    import brPkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        reqValid,
    input  branchReq_t  reqData,
    input  logic        respCredit,
    output logic        reqCredit,
    output logic        respValid,
    output branchResp_t respData
);

    branchReq_t headReq;
    logic       notEmpty;
    logic       issue;
    logic       stageValid;
    logic       taken;
    brTag_t     stageTag;
    word_t      target;
    word_t      fallThrough;

    // Request buffer, sized to the sender's credits
    creditQueue #(
        .payload_t (branchReq_t),
        .DEPTH     (QUEUE_DEPTH)
    ) reqQueue (
        .clk      (clk),
        .rst      (rst),
        .push     (reqValid),
        .pushData (reqData),
        .pop      (issue),
        .headData (headReq),
        .notEmpty (notEmpty)
    );

    condEval condStage (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .req        (headReq),
        .stageValid (stageValid),
        .taken      (taken),
        .tag        (stageTag)
    );

    targetAdder addStage (
        .clk         (clk),
        .issue       (issue),
        .req         (headReq),
        .target      (target),
        .fallThrough (fallThrough)
    );

    pcResolve #(
        .OUT_CREDITS (OUT_CREDITS)
    ) resolver (
        .clk         (clk),
        .rst         (rst),
        .notEmpty    (notEmpty),
        .stageValid  (stageValid),
        .taken       (taken),
        .tag         (stageTag),
        .target      (target),
        .fallThrough (fallThrough),
        .respCredit  (respCredit),
        .issue       (issue),
        .reqCredit   (reqCredit),
        .respValid   (respValid),
        .respData    (respData)
    );

endmodule

// File: pcResolve.sv
module pcResolve
    import brPkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        notEmpty,
    input  logic        stageValid,
    input  logic        taken,
    input  brTag_t      tag,
    input  word_t       target,
    input  word_t       fallThrough,
    input  logic        respCredit,
    output logic        issue,
    output logic        reqCredit,
    output logic        respValid,
    output branchResp_t respData
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;   // Responses the consumer can still take
    logic [CNT_W-1:0] inFlight;  // Issued, response not yet sent

    // Every issued item already owns a credit
    assign issue = notEmpty && (credits > inFlight);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({respCredit, respValid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= '0;
        end else begin
            case ({issue, respValid})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    // Queue slot freed by the pop, hand the credit back
    always_ff @(posedge clk) begin
        if (rst) begin
            reqCredit <= 1'b0;
            respValid <= 1'b0;
        end else begin
            reqCredit <= issue;
            respValid <= stageValid;
        end
    end

    // Select the next PC
    always_ff @(posedge clk) begin
        if (stageValid) begin
            respData.tag    <= tag;
            respData.taken  <= taken;
            respData.nextPc <= taken ? target : fallThrough;
        end
    end

endmodule

// File: targetAdder.sv
module targetAdder
    import brPkg::*;
(
    input  logic       clk,
    input  logic       issue,
    input  branchReq_t req,
    output word_t      target,
    output word_t      fallThrough
);

    word_t incPc;
    word_t constExt;

    assign incPc = req.pc + 1'b1;

    // Sign-extend C to a full word
    assign constExt = {{(WORD_W - CONST_W){req.ir[CONST_HI]}}, req.ir[CONST_HI:CONST_LO]};

    // Captured alongside condEval, so stageValid covers both
    always_ff @(posedge clk) begin
        if (issue) begin
            fallThrough <= incPc;
            target      <= incPc + constExt;  // Wraps at 32 bits
        end
    end

endmodule

// File: condEval.sv
module condEval
    import brPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    input  branchReq_t req,
    output logic       stageValid,
    output logic       taken,
    output brTag_t     tag
);

    brCond_e cond;
    logic    isBranch;
    logic    condMet;

    assign cond     = brCond_e'(req.ir[COND_HI:COND_LO]);
    assign isBranch = (req.ir[OPCODE_HI:OPCODE_LO] == BR_OPCODE);

    // Test Ra against the condition field
    always_comb begin
        case (cond)
            brZero:    condMet = (req.raValue == '0);
            brNonZero: condMet = (req.raValue != '0);
            brPlus:    condMet = ~req.raValue[WORD_W-1];
            brMinus:   condMet = req.raValue[WORD_W-1];
            default:   condMet = 1'b0;
        endcase
    end

    // Valid flag also qualifies the target adder outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= issue;
        end
    end

    // CON flip-flop
    always_ff @(posedge clk) begin
        if (issue) begin
            taken <= isBranch & condMet;  // Non-branch falls through
            tag   <= req.tag;
        end
    end

endmodule

// File: creditQueue.sv
module creditQueue
    import brPkg::*;
#(
    parameter type payload_t = word_t,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t headData,
    output logic     notEmpty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];  // Circular storage

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    // Sender holds credits, so push never finds the buffer full
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    assign headData = mem[rdPtr];  // Oldest entry
    assign notEmpty = (count != '0);

endmodule

// File: brPkg.sv
package brPkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;  // Data and address word

    // Instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 27;
    localparam int RA_HI     = 26;
    localparam int RA_LO     = 23;
    localparam int COND_HI   = 20;
    localparam int COND_LO   = 19;
    localparam int CONST_HI  = 18;
    localparam int CONST_LO  = 0;
    localparam int CONST_W   = CONST_HI - CONST_LO + 1;  // Signed immediate width

    // Conditional branch opcode (brzr, brnz, brpl, brmi share it)
    localparam logic [OPCODE_HI-OPCODE_LO:0] BR_OPCODE = 5'b10010;

    // Condition field of the branch, tested against Ra
    typedef enum logic [COND_HI-COND_LO:0] {
        brZero    = 2'b00,  // Ra == 0
        brNonZero = 2'b01,  // Ra != 0
        brPlus    = 2'b10,  // Ra[31] clear
        brMinus   = 2'b11   // Ra[31] set
    } brCond_e;

    typedef logic [7:0] brTag_t;  // Echoed back for order checks

    // Request into the branch unit, 104 bits
    typedef struct packed {
        brTag_t tag;
        word_t  pc;
        word_t  ir;
        word_t  raValue;   // Contents of register Ra
    } branchReq_t;

    // Resolved branch, 41 bits
    typedef struct packed {
        brTag_t tag;
        word_t  nextPc;
        logic   taken;
    } branchResp_t;

endpackage
